// File: source/rasterix_params.svh
// Rasterix shared screen, stream and command opcode constants
`ifndef RASTERIX_PARAMS_SVH
`define RASTERIX_PARAMS_SVH

// Screen geometry
`define X_RESOLUTION 16
`define Y_RESOLUTION 16
`define FRAME_SIZE (`X_RESOLUTION * `Y_RESOLUTION)
`define INDEX_WIDTH 8

// Stream widths
`define CMD_WIDTH 32
`define PIXEL_WIDTH 16

// Opcodes in the top nibble of a header word
`define OP_RENDER 4'd1
`define OP_CLEAR 4'd2
`define OP_COMMIT 4'd3
`define TRIANGLE_WORDS 15
`define DEPTH_FAR 16'hffff

`endif

// File: source/RasterixPkg.sv
// Rasterix shared types for commands, triangles, fragments and buffer writes
package RasterixPkg;
`include "rasterix_params.svh"

    typedef logic [`CMD_WIDTH - 1 : 0] cmdWord_t;
    // RGB565 color or unsigned depth
    typedef logic [`PIXEL_WIDTH - 1 : 0] pixel_t;
    // y * X_RESOLUTION + x
    typedef logic [`INDEX_WIDTH - 1 : 0] fbIndex_t;
    typedef logic [7:0] screenCoord_t;
    typedef logic signed [31:0] edgeValue_t;

    typedef struct packed {
        screenCoord_t bbStartX;
        screenCoord_t bbStartY;
        screenCoord_t bbEndX;
        screenCoord_t bbEndY;
        edgeValue_t   w0;
        edgeValue_t   w1;
        edgeValue_t   w2;
        edgeValue_t   w0IncX;
        edgeValue_t   w1IncX;
        edgeValue_t   w2IncX;
        edgeValue_t   w0IncY;
        edgeValue_t   w1IncY;
        edgeValue_t   w2IncY;
        edgeValue_t   z;
        edgeValue_t   zIncX;
        edgeValue_t   zIncY;
        pixel_t       color;
    } triangleParams_t;

    typedef struct packed {
        logic     valid;
        fbIndex_t index;
        pixel_t   depth;
    } fragment_t;

    typedef struct packed {
        logic     enable;
        fbIndex_t index;
        pixel_t   data;
    } bufferWrite_t;

    typedef enum logic [2:0] {IDLE, LOAD_PARAMS, RENDER, CLEAR, COMMIT} parserState_t;

endpackage

// File: source/CommandParser.sv
// Command decoder with the triangle register bank, sequencing render, clear and commit
`timescale 1ns/1ps
`include "rasterix_params.svh"

module CommandParser import RasterixPkg::*; (
    input  logic            aclk,
    input  logic            rst,

    // Command stream
    input  logic            cmdValid,
    output logic            cmdReady,
    input  cmdWord_t        cmdData,

    // Rendering control
    output triangleParams_t triangle,
    output logic            startRendering,
    input  logic            rasterizerRunning,
    input  logic            pixelInPipeline,

    // Buffer control
    output pixel_t          clearColor,
    output logic            colorClear,
    output logic            depthClear,
    input  logic            colorCleared,
    input  logic            depthCleared,
    output logic            commit,
    input  logic            streamDone
);
    parserState_t state;
    logic [3:0]   wordCount;
    logic         colorDone;
    logic         depthDone;
    logic         cmdAccepted;
    logic [3:0]   opcode;

    // New words only while idle or collecting parameters
    assign cmdReady    = (state == IDLE) || (state == LOAD_PARAMS);
    assign cmdAccepted = cmdValid && cmdReady;
    assign opcode      = cmdData[`CMD_WIDTH - 1 -: 4];

    ////////////////////////////////////////////////////////////////////////////
    // Command sequencer
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge aclk) begin
        if (rst) begin
            state          <= IDLE;
            wordCount      <= '0;
            startRendering <= 1'b0;
            colorClear     <= 1'b0;
            depthClear     <= 1'b0;
            commit         <= 1'b0;
            colorDone      <= 1'b0;
            depthDone      <= 1'b0;
        end else begin
            startRendering <= 1'b0;
            colorClear     <= 1'b0;
            depthClear     <= 1'b0;
            commit         <= 1'b0;
            case (state)
                IDLE: begin
                    if (cmdAccepted) begin
                        case (opcode)
                            `OP_RENDER: begin
                                state     <= LOAD_PARAMS;
                                wordCount <= '0;
                            end
                            `OP_CLEAR: begin
                                state      <= CLEAR;
                                colorClear <= 1'b1;
                                depthClear <= 1'b1;
                                colorDone  <= 1'b0;
                                depthDone  <= 1'b0;
                            end
                            `OP_COMMIT: begin
                                state  <= COMMIT;
                                commit <= 1'b1;
                            end
                            // Unknown opcodes are dropped
                            default: state <= IDLE;
                        endcase
                    end
                end
                LOAD_PARAMS: begin
                    if (cmdAccepted) begin
                        wordCount <= wordCount + 4'd1;
                        if (wordCount == 4'(`TRIANGLE_WORDS - 1)) begin
                            state          <= RENDER;
                            startRendering <= 1'b1;
                        end
                    end
                end
                RENDER: begin
                    // Skip the start cycle, the rasterizer has not risen yet
                    if (!startRendering && !rasterizerRunning && !pixelInPipeline) begin
                        state <= IDLE;
                    end
                end
                CLEAR: begin
                    colorDone <= colorDone || colorCleared;
                    depthDone <= depthDone || depthCleared;
                    if ((colorDone || colorCleared) && (depthDone || depthCleared)) begin
                        state <= IDLE;
                    end
                end
                COMMIT: begin
                    if (streamDone) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Triangle register bank and clear color
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge aclk) begin
        if ((state == IDLE) && cmdAccepted && (opcode == `OP_CLEAR)) begin
            clearColor <= cmdData[15:0];
        end
        if ((state == LOAD_PARAMS) && cmdAccepted) begin
            case (wordCount)
                4'd0: begin
                    triangle.bbStartX <= cmdData[7:0];
                    triangle.bbStartY <= cmdData[15:8];
                end
                4'd1: begin
                    triangle.bbEndX <= cmdData[7:0];
                    triangle.bbEndY <= cmdData[15:8];
                end
                4'd2:  triangle.w0     <= cmdData;
                4'd3:  triangle.w1     <= cmdData;
                4'd4:  triangle.w2     <= cmdData;
                4'd5:  triangle.w0IncX <= cmdData;
                4'd6:  triangle.w1IncX <= cmdData;
                4'd7:  triangle.w2IncX <= cmdData;
                4'd8:  triangle.w0IncY <= cmdData;
                4'd9:  triangle.w1IncY <= cmdData;
                4'd10: triangle.w2IncY <= cmdData;
                4'd11: triangle.z      <= cmdData;
                4'd12: triangle.zIncX  <= cmdData;
                4'd13: triangle.zIncY  <= cmdData;
                default: triangle.color <= cmdData[15:0];
            endcase
        end
    end

endmodule

// File: source/Rasterizer.sv
// Bounding box walker with incremental edge and depth functions, one pixel per cycle
`timescale 1ns/1ps
`include "rasterix_params.svh"

module Rasterizer import RasterixPkg::*; (
    input  logic            aclk,
    input  logic            rst,
    input  logic            startRendering,
    input  triangleParams_t triangle,
    output logic            rasterizerRunning,
    output fragment_t       fragment
);
    screenCoord_t x;
    screenCoord_t y;
    edgeValue_t   w0;
    edgeValue_t   w1;
    edgeValue_t   w2;
    edgeValue_t   z;
    // Values at the start of the current row
    edgeValue_t   w0Row;
    edgeValue_t   w1Row;
    edgeValue_t   w2Row;
    edgeValue_t   zRow;
    logic         lastX;
    logic         lastY;

    assign lastX = (x == triangle.bbEndX - 8'd1);
    assign lastY = (y == triangle.bbEndY - 8'd1);

    // Covered when no edge is negative
    assign fragment.valid = rasterizerRunning && !w0[31] && !w1[31] && !w2[31];
    assign fragment.index = fbIndex_t'(y * `X_RESOLUTION) + fbIndex_t'(x);
    assign fragment.depth = z[31:16];

    always_ff @(posedge aclk) begin
        if (rst) begin
            rasterizerRunning <= 1'b0;
        end else if (startRendering) begin
            rasterizerRunning <= (triangle.bbStartX < triangle.bbEndX)
                              && (triangle.bbStartY < triangle.bbEndY);
        end else if (rasterizerRunning && lastX && lastY) begin
            rasterizerRunning <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (startRendering) begin
            x     <= triangle.bbStartX;
            y     <= triangle.bbStartY;
            w0    <= triangle.w0;
            w1    <= triangle.w1;
            w2    <= triangle.w2;
            z     <= triangle.z;
            w0Row <= triangle.w0;
            w1Row <= triangle.w1;
            w2Row <= triangle.w2;
            zRow  <= triangle.z;
        end else if (rasterizerRunning) begin
            if (lastX) begin
                // Next row from the row start values
                x     <= triangle.bbStartX;
                y     <= y + 8'd1;
                w0    <= w0Row + triangle.w0IncY;
                w1    <= w1Row + triangle.w1IncY;
                w2    <= w2Row + triangle.w2IncY;
                z     <= zRow + triangle.zIncY;
                w0Row <= w0Row + triangle.w0IncY;
                w1Row <= w1Row + triangle.w1IncY;
                w2Row <= w2Row + triangle.w2IncY;
                zRow  <= zRow + triangle.zIncY;
            end else begin
                x  <= x + 8'd1;
                w0 <= w0 + triangle.w0IncX;
                w1 <= w1 + triangle.w1IncX;
                w2 <= w2 + triangle.w2IncX;
                z  <= z + triangle.zIncX;
            end
        end
    end

endmodule

// File: source/FragmentPipeline.sv
// Two stage depth test that writes fragment depth and flat color on pass
`timescale 1ns/1ps

module FragmentPipeline import RasterixPkg::*; (
    input  logic            aclk,
    input  logic            rst,
    input  fragment_t       fragment,
    input  triangleParams_t triangle,

    // Depth buffer access
    output fbIndex_t        depthReadIndex,
    input  pixel_t          depthReadData,
    output bufferWrite_t    depthWrite,

    output bufferWrite_t    colorWrite,
    output logic            pixelInPipeline
);
    fragment_t stage1;
    fragment_t stage2;
    logic      depthPass;

    // Stage one issues the read, stage two sees the stored depth
    always_ff @(posedge aclk) begin
        stage1 <= fragment;
        stage2 <= stage1;
        if (rst) begin
            stage1.valid <= 1'b0;
            stage2.valid <= 1'b0;
        end
    end

    assign depthReadIndex  = stage1.index;
    assign pixelInPipeline = stage1.valid || stage2.valid;

    // Strictly nearer wins
    assign depthPass = stage2.valid && (stage2.depth < depthReadData);

    assign depthWrite.enable = depthPass;
    assign depthWrite.index  = stage2.index;
    assign depthWrite.data   = stage2.depth;

    assign colorWrite.enable = depthPass;
    assign colorWrite.index  = stage2.index;
    assign colorWrite.data   = triangle.color;

endmodule

// File: source/FrameBuffer.sv
// Pixel memory with a registered read port, a write port and a clear engine
`timescale 1ns/1ps
`include "rasterix_params.svh"

module FrameBuffer import RasterixPkg::*; (
    input  logic         aclk,
    input  logic         rst,
    input  fbIndex_t     readIndex,
    output pixel_t       readData,
    input  bufferWrite_t write,
    input  logic         clear,
    input  pixel_t       clearValue,
    output logic         cleared
);
    pixel_t   mem [`FRAME_SIZE];
    fbIndex_t clearIndex;
    pixel_t   fillValue;
    logic     clearing;

    always_ff @(posedge aclk) begin
        readData <= mem[readIndex];
        // Clear engine has priority over the write port
        if (clearing) begin
            mem[clearIndex] <= fillValue;
        end else if (write.enable) begin
            mem[write.index] <= write.data;
        end
    end

    always_ff @(posedge aclk) begin
        if (clear) begin
            fillValue  <= clearValue;
            clearIndex <= '0;
        end else if (clearing) begin
            clearIndex <= clearIndex + 1'b1;
        end
    end

    always_ff @(posedge aclk) begin
        if (rst) begin
            clearing <= 1'b0;
            cleared  <= 1'b0;
        end else begin
            cleared <= 1'b0;
            if (clear) begin
                clearing <= 1'b1;
            end else if (clearing && (clearIndex == fbIndex_t'(`FRAME_SIZE - 1))) begin
                clearing <= 1'b0;
                cleared  <= 1'b1;
            end
        end
    end

endmodule

// File: source/FramebufferStreamer.sv
// Streams the color buffer in index order onto the output under back-pressure
`timescale 1ns/1ps
`include "rasterix_params.svh"

module FramebufferStreamer import RasterixPkg::*; (
    input  logic     aclk,
    input  logic     rst,
    input  logic     commit,
    output fbIndex_t readIndex,
    input  pixel_t   readData,
    output logic     fbValid,
    input  logic     fbReady,
    output logic     fbLast,
    output pixel_t   fbData,
    output logic     streamDone
);
    fbIndex_t counter;
    logic     active;
    logic     load;
    logic     lastWord;

    // Output register is free or drains this cycle
    assign load     = active && (!fbValid || fbReady);
    assign lastWord = (counter == fbIndex_t'(`FRAME_SIZE - 1));

    // Address the next counter value so readData always matches counter
    assign readIndex  = commit ? '0 : (load ? counter + 1'b1 : counter);
    assign streamDone = fbValid && fbReady && fbLast;

    always_ff @(posedge aclk) begin
        if (rst) begin
            counter <= '0;
            active  <= 1'b0;
            fbValid <= 1'b0;
            fbLast  <= 1'b0;
        end else if (commit) begin
            counter <= '0;
            active  <= 1'b1;
        end else if (load) begin
            counter <= counter + 1'b1;
            fbValid <= 1'b1;
            fbLast  <= lastWord;
            if (lastWord) begin
                active <= 1'b0;
            end
        end else if (fbValid && fbReady) begin
            fbValid <= 1'b0;
            fbLast  <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (load) begin
            fbData <= readData;
        end
    end

endmodule

// File: source/Rasterix.sv
// Rasterix top level connecting parser, rasterizer, fragment stage, buffers and streamer
`timescale 1ns/1ps
`include "rasterix_params.svh"

module Rasterix import RasterixPkg::*; (
    input  logic     aclk,
    input  logic     rst,

    // Command stream
    input  logic     cmdValid,
    output logic     cmdReady,
    input  cmdWord_t cmdData,

    // Framebuffer stream
    output logic     fbValid,
    input  logic     fbReady,
    output logic     fbLast,
    output pixel_t   fbData
);
    triangleParams_t triangle;
    fragment_t       fragment;
    logic            startRendering;
    logic            rasterizerRunning;
    logic            pixelInPipeline;

    // Buffer control
    pixel_t          clearColor;
    logic            colorClear;
    logic            depthClear;
    logic            colorCleared;
    logic            depthCleared;
    logic            commit;
    logic            streamDone;

    // Buffer ports
    fbIndex_t        depthReadIndex;
    pixel_t          depthReadData;
    bufferWrite_t    depthWrite;
    fbIndex_t        colorReadIndex;
    pixel_t          colorReadData;
    bufferWrite_t    colorWrite;

    CommandParser commandParser (
        .aclk(aclk),
        .rst(rst),
        .cmdValid(cmdValid),
        .cmdReady(cmdReady),
        .cmdData(cmdData),
        .triangle(triangle),
        .startRendering(startRendering),
        .rasterizerRunning(rasterizerRunning),
        .pixelInPipeline(pixelInPipeline),
        .clearColor(clearColor),
        .colorClear(colorClear),
        .depthClear(depthClear),
        .colorCleared(colorCleared),
        .depthCleared(depthCleared),
        .commit(commit),
        .streamDone(streamDone)
    );

    Rasterizer rasterizer (
        .aclk(aclk),
        .rst(rst),
        .startRendering(startRendering),
        .triangle(triangle),
        .rasterizerRunning(rasterizerRunning),
        .fragment(fragment)
    );

    FragmentPipeline fragmentPipeline (
        .aclk(aclk),
        .rst(rst),
        .fragment(fragment),
        .triangle(triangle),
        .depthReadIndex(depthReadIndex),
        .depthReadData(depthReadData),
        .depthWrite(depthWrite),
        .colorWrite(colorWrite),
        .pixelInPipeline(pixelInPipeline)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Buffers and output
    ////////////////////////////////////////////////////////////////////////////
    FrameBuffer colorBuffer (
        .aclk(aclk),
        .rst(rst),
        .readIndex(colorReadIndex),
        .readData(colorReadData),
        .write(colorWrite),
        .clear(colorClear),
        .clearValue(clearColor),
        .cleared(colorCleared)
    );

    // Depth always clears to the far plane
    FrameBuffer depthBuffer (
        .aclk(aclk),
        .rst(rst),
        .readIndex(depthReadIndex),
        .readData(depthReadData),
        .write(depthWrite),
        .clear(depthClear),
        .clearValue(`DEPTH_FAR),
        .cleared(depthCleared)
    );

    FramebufferStreamer framebufferStreamer (
        .aclk(aclk),
        .rst(rst),
        .commit(commit),
        .readIndex(colorReadIndex),
        .readData(colorReadData),
        .fbValid(fbValid),
        .fbReady(fbReady),
        .fbLast(fbLast),
        .fbData(fbData),
        .streamDone(streamDone)
    );

endmodule

// File: tests/RasterixTb.sv
// Rasterix testbench with a pixel reference model and stream assertions
`timescale 1ns/1ps
`include "rasterix_params.svh"

module RasterixTb import RasterixPkg::*; ();
    // 53 command words, one clear and three commits
    localparam int COMMAND_WORDS   = 53;
    localparam int FRAME_PASSES    = 4;
    localparam int WATCHDOG_CYCLES = 20 * (COMMAND_WORDS + FRAME_PASSES * `FRAME_SIZE) + 16;

    logic     aclk;
    logic     rst;
    logic     cmdValid;
    logic     cmdReady;
    cmdWord_t cmdData;
    logic     fbValid;
    logic     fbReady;
    logic     fbLast;
    pixel_t   fbData;

    pixel_t   modelColor [`FRAME_SIZE];
    pixel_t   modelDepth [`FRAME_SIZE];
    fbIndex_t beatCount;
    int       framesSeen;
    pixel_t   expectedBeat;
    logic     randomReady;
    int       seed;
    int       readyDraw;

    Rasterix dut (
        .aclk(aclk),
        .rst(rst),
        .cmdValid(cmdValid),
        .cmdReady(cmdReady),
        .cmdData(cmdData),
        .fbValid(fbValid),
        .fbReady(fbReady),
        .fbLast(fbLast),
        .fbData(fbData)
    );

    always #5 aclk = ~aclk;

    task automatic failRun(input string reason);
        $display("%s", reason);
        $display("Checks failed");
        $fatal(1, "Stopped at the first failure");
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Output monitor and assertions
    ////////////////////////////////////////////////////////////////////////////
    assign expectedBeat = modelColor[beatCount];

    always @(posedge aclk) begin
        if (rst) begin
            beatCount  <= '0;
            framesSeen <= 0;
        end else if (fbValid && fbReady) begin
            beatCount <= beatCount + 1'b1;
            if (fbLast) begin
                beatCount  <= '0;
                framesSeen <= framesSeen + 1;
            end
        end
    end

    // Random back-pressure only while enabled
    always @(posedge aclk) begin
        readyDraw = $random(seed);
        fbReady <= randomReady ? readyDraw[0] : 1'b1;
    end

    assert property (@(posedge aclk) $fell(rst) |-> (cmdReady && !fbValid))
        else failRun("cmdReady or fbValid wrong right after reset");

    assert property (@(posedge aclk) disable iff (rst)
        (fbValid && fbReady) |-> (fbData == expectedBeat))
        else failRun($sformatf("[ERROR] fbData expected %h actual %h",
            $sampled(expectedBeat), $sampled(fbData)));

    assert property (@(posedge aclk) disable iff (rst)
        (fbValid && fbReady) |-> (fbLast == (beatCount == fbIndex_t'(`FRAME_SIZE - 1))))
        else failRun($sformatf("[ERROR] fbLast expected %h actual %h",
            $sampled(beatCount == fbIndex_t'(`FRAME_SIZE - 1)), $sampled(fbLast)));

    assert property (@(posedge aclk) disable iff (rst)
        (fbValid && !fbReady) |=> (fbValid && $stable(fbData) && $stable(fbLast)))
        else failRun("Output beat dropped or changed while the stream was stalled");

    ////////////////////////////////////////////////////////////////////////////
    // Triangle setup and reference model
    ////////////////////////////////////////////////////////////////////////////
    // Positive on the inner side of a counter-clockwise edge a to b
    function automatic edgeValue_t edgeAt(input int xa, ya, xb, yb, x, y);
        return (y - ya) * (xb - xa) - (x - xa) * (yb - ya);
    endfunction

    function automatic int minOf3(input int a, b, c);
        return (a < b) ? ((a < c) ? a : c) : ((b < c) ? b : c);
    endfunction

    function automatic int maxOf3(input int a, b, c);
        return (a > b) ? ((a > c) ? a : c) : ((b > c) ? b : c);
    endfunction

    function automatic triangleParams_t makeTriangle(input int ax, ay, bx, by, cx, cy,
            input int z, zIncX, zIncY, input pixel_t color);
        triangleParams_t t;
        int sx;
        int sy;
        sx = minOf3(ax, bx, cx);
        sy = minOf3(ay, by, cy);
        t.bbStartX = screenCoord_t'(sx);
        t.bbStartY = screenCoord_t'(sy);
        // End of the box is exclusive
        t.bbEndX   = screenCoord_t'(maxOf3(ax, bx, cx) + 1);
        t.bbEndY   = screenCoord_t'(maxOf3(ay, by, cy) + 1);
        t.w0       = edgeAt(ax, ay, bx, by, sx, sy);
        t.w1       = edgeAt(bx, by, cx, cy, sx, sy);
        t.w2       = edgeAt(cx, cy, ax, ay, sx, sy);
        t.w0IncX   = ay - by;
        t.w1IncX   = by - cy;
        t.w2IncX   = cy - ay;
        t.w0IncY   = bx - ax;
        t.w1IncY   = cx - bx;
        t.w2IncY   = ax - cx;
        t.z        = z;
        t.zIncX    = zIncX;
        t.zIncY    = zIncY;
        t.color    = color;
        return t;
    endfunction

    task automatic applyToModel(input triangleParams_t t);
        edgeValue_t e0;
        edgeValue_t e1;
        edgeValue_t e2;
        edgeValue_t zv;
        int         dx;
        int         dy;
        int         idx;
        for (int y = t.bbStartY; y < t.bbEndY; y++) begin
            for (int x = t.bbStartX; x < t.bbEndX; x++) begin
                dx  = x - int'(t.bbStartX);
                dy  = y - int'(t.bbStartY);
                e0  = t.w0 + dx * t.w0IncX + dy * t.w0IncY;
                e1  = t.w1 + dx * t.w1IncX + dy * t.w1IncY;
                e2  = t.w2 + dx * t.w2IncX + dy * t.w2IncY;
                zv  = t.z + dx * t.zIncX + dy * t.zIncY;
                idx = y * `X_RESOLUTION + x;
                if (e0 >= 0 && e1 >= 0 && e2 >= 0 && zv[31:16] < modelDepth[idx]) begin
                    modelDepth[idx] = zv[31:16];
                    modelColor[idx] = t.color;
                end
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Command stimulus
    ////////////////////////////////////////////////////////////////////////////
    task automatic sendWord(input cmdWord_t word);
        cmdValid <= 1'b1;
        cmdData  <= word;
        @(posedge aclk);
        while (!cmdReady) @(posedge aclk);
        cmdValid <= 1'b0;
    endtask

    task automatic clearBuffers(input pixel_t color);
        for (int i = 0; i < `FRAME_SIZE; i++) begin
            modelColor[i] = color;
            modelDepth[i] = `DEPTH_FAR;
        end
        sendWord({`OP_CLEAR, 12'd0, color});
    endtask

    task automatic renderTriangle(input triangleParams_t t);
        applyToModel(t);
        sendWord({`OP_RENDER, 28'd0});
        sendWord({16'd0, t.bbStartY, t.bbStartX});
        sendWord({16'd0, t.bbEndY, t.bbEndX});
        sendWord(t.w0);
        sendWord(t.w1);
        sendWord(t.w2);
        sendWord(t.w0IncX);
        sendWord(t.w1IncX);
        sendWord(t.w2IncX);
        sendWord(t.w0IncY);
        sendWord(t.w1IncY);
        sendWord(t.w2IncY);
        sendWord(t.z);
        sendWord(t.zIncX);
        sendWord(t.zIncY);
        sendWord({16'd0, t.color});
    endtask

    // Waits until the whole frame has left the stream
    task automatic commitFrame();
        int framesBefore;
        framesBefore = framesSeen;
        sendWord({`OP_COMMIT, 28'd0});
        while (framesSeen == framesBefore) @(posedge aclk);
    endtask

    initial begin
        #(WATCHDOG_CYCLES * 10);
        failRun("Timeout, the DUT did not finish the command sequence");
    end

    initial begin
        aclk        = 1'b0;
        rst         = 1'b1;
        cmdValid    = 1'b0;
        cmdData     = '0;
        fbReady     = 1'b1;
        randomReady = 1'b0;
        seed        = 63;
        repeat (16) @(posedge aclk);
        rst <= 1'b0;

        // Unknown opcode is swallowed, then a plain cleared frame
        sendWord({4'hf, 28'h0000123});
        clearBuffers(16'h18e3);
        commitFrame();

        renderTriangle(makeTriangle(2, 2, 12, 4, 4, 13,
            32'h4000_0000, 32'h0010_0000, 32'h0008_0000, 16'hf800));
        commitFrame();

        // Nearer triangle overwrites, farther one only fills uncovered pixels
        renderTriangle(makeTriangle(6, 1, 15, 9, 1, 11,
            32'h2000_0000, 32'h0004_0000, -32'sh0002_0000, 16'h07e0));
        renderTriangle(makeTriangle(3, 5, 14, 7, 8, 15,
            32'h6000_0000, -32'sh0001_0000, 32'h0003_0000, 16'h001f));
        randomReady <= 1'b1;
        commitFrame();
        randomReady <= 1'b0;
        @(posedge aclk);

        $display("All checks passed");
        $finish;
    end

endmodule

// File: build.f
+incdir+source
source/RasterixPkg.sv
source/CommandParser.sv
source/Rasterizer.sv
source/FragmentPipeline.sv
source/FrameBuffer.sv
source/FramebufferStreamer.sv
source/Rasterix.sv
tests/RasterixTb.sv
